//--- src/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [2:0]  funct3_t;

   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011,
      OPC_BRANCH = 7'b1100011,
      OPC_JAL    = 7'b1101111
   } opcode_e;

   // funct3 of register-register ops
   typedef enum logic [2:0] {
      F3_ADD_SUB = 3'b000,
      F3_SLT     = 3'b010,
      F3_XOR     = 3'b100,
      F3_OR      = 3'b110,
      F3_AND     = 3'b111
   } funct3_op_e;

   typedef enum logic [6:0] {
      F7_BASE = 7'b0000000,
      F7_ALT  = 7'b0100000   // SUB
   } funct7_e;

   localparam funct3_t F3_ADDI = 3'b000;
   localparam funct3_t F3_WORD = 3'b010;   // LW and SW
   localparam funct3_t F3_BEQ  = 3'b000;
   localparam funct3_t F3_BNE  = 3'b001;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_PASS_B
   } alu_op_e;

   localparam word_t NOP_WORD = 32'h0000_0013;   // addi x0, x0, 0

endpackage

`default_nettype wire

//--- src/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

   localparam int MEM_WORDS  = 1024;
   localparam int MEM_ADDR_W = 10;

   typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

   typedef struct packed {
      rv_isa_pkg::alu_op_e alu_op;
      logic                use_imm;
      logic                reg_write;
      logic                mem_read;
      logic                mem_write;
      logic                is_branch;
      logic                branch_ne;   // BNE when set, else BEQ
      logic                is_jal;
   } ctrl_t;

   typedef struct packed {
      logic              valid;
      rv_isa_pkg::word_t pc;
      rv_isa_pkg::word_t instr;
   } if_id_t;

   typedef struct packed {
      logic                 valid;
      rv_isa_pkg::word_t    pc;
      rv_isa_pkg::reg_idx_t rs1;
      rv_isa_pkg::reg_idx_t rs2;
      rv_isa_pkg::reg_idx_t rd;
      rv_isa_pkg::word_t    op1;
      rv_isa_pkg::word_t    op2;
      rv_isa_pkg::word_t    imm;
      ctrl_t                ctrl;
   } id_ex_t;

   typedef struct packed {
      logic                 valid;
      rv_isa_pkg::word_t    pc;
      rv_isa_pkg::reg_idx_t rd;
      rv_isa_pkg::word_t    alu_result;
      rv_isa_pkg::word_t    store_data;
      ctrl_t                ctrl;
   } ex_mem_t;

   typedef struct packed {
      logic                 valid;
      rv_isa_pkg::word_t    pc;
      rv_isa_pkg::reg_idx_t rd;
      rv_isa_pkg::word_t    result;
      logic                 reg_write;
   } mem_wb_t;

   typedef struct packed {
      logic                 valid;
      rv_isa_pkg::word_t    pc;
      rv_isa_pkg::reg_idx_t rd;
      rv_isa_pkg::word_t    wdata;
      logic                 we;
   } retire_t;

   // Empty decode slot
   localparam if_id_t IF_BUBBLE = '{valid: 1'b0, pc: '0, instr: rv_isa_pkg::NOP_WORD};

endpackage

`default_nettype wire

//--- src/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
   input  logic              clk,
   input  logic              reset,
   input  logic              hold_i,
   input  logic              redirect_i,
   input  rv_isa_pkg::word_t target_i,
   output logic              fetch_req_o,
   output rv_isa_pkg::word_t fetch_addr_o,
   output rv_isa_pkg::word_t pc_o
);

   rv_isa_pkg::word_t pc;

   // Redirect beats hold
   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
      end else if (redirect_i) begin
         pc <= target_i;
      end else if (!hold_i) begin
         pc <= pc + 32'd4;
      end
   end

   // Grant is resolved against the data port in the top
   assign fetch_req_o  = 1'b1;
   assign fetch_addr_o = pc;
   assign pc_o         = pc;

   a_target_aligned : assert property (
      @(posedge clk) disable iff (reset)
      redirect_i |-> (target_i[1:0] == 2'b00)
   ) else $error("fetch_unit: misaligned redirect target %h", target_i);

endmodule

`default_nettype wire

//--- src/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
   input  rv_isa_pkg::word_t    instr_i,
   output rv_isa_pkg::reg_idx_t rs1_o,
   output rv_isa_pkg::reg_idx_t rs2_o,
   output rv_isa_pkg::reg_idx_t rd_o,
   output rv_isa_pkg::word_t    imm_o,
   output rv_pipe_pkg::ctrl_t   ctrl_o
);

   rv_isa_pkg::opcode_e opcode;
   rv_isa_pkg::funct3_t funct3;
   logic [6:0]          funct7;
   logic                op_legal;
   logic                use_rs1;
   logic                use_rs2;

   assign opcode   = rv_isa_pkg::opcode_e'(instr_i[6:0]);
   assign funct3   = instr_i[14:12];
   assign funct7   = instr_i[31:25];
   assign op_legal = (funct7 == rv_isa_pkg::F7_BASE) ||
                     (funct7 == rv_isa_pkg::F7_ALT && funct3 == rv_isa_pkg::F3_ADD_SUB);

   assign rd_o  = instr_i[11:7];
   assign rs1_o = use_rs1 ? instr_i[19:15] : '0;   // Unused sources read x0
   assign rs2_o = use_rs2 ? instr_i[24:20] : '0;

   always_comb begin
      ctrl_o  = '0;
      use_rs1 = 1'b0;
      use_rs2 = 1'b0;
      imm_o   = {{20{instr_i[31]}}, instr_i[31:20]};
      case (opcode)
         rv_isa_pkg::OPC_OP: begin
            use_rs1          = 1'b1;
            use_rs2          = 1'b1;
            ctrl_o.reg_write = op_legal;
            case (funct3)
               rv_isa_pkg::F3_ADD_SUB: ctrl_o.alu_op = (funct7 == rv_isa_pkg::F7_ALT) ?
                                                       rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
               rv_isa_pkg::F3_SLT: ctrl_o.alu_op = rv_isa_pkg::ALU_SLT;
               rv_isa_pkg::F3_XOR: ctrl_o.alu_op = rv_isa_pkg::ALU_XOR;
               rv_isa_pkg::F3_OR:  ctrl_o.alu_op = rv_isa_pkg::ALU_OR;
               rv_isa_pkg::F3_AND: ctrl_o.alu_op = rv_isa_pkg::ALU_AND;
               default:            ctrl_o.reg_write = 1'b0;
            endcase
         end
         rv_isa_pkg::OPC_OP_IMM: begin
            use_rs1          = 1'b1;
            ctrl_o.use_imm   = 1'b1;
            ctrl_o.reg_write = (funct3 == rv_isa_pkg::F3_ADDI);   // ADDI only
         end
         rv_isa_pkg::OPC_LUI: begin
            imm_o            = {instr_i[31:12], 12'b0};
            ctrl_o.alu_op    = rv_isa_pkg::ALU_PASS_B;
            ctrl_o.use_imm   = 1'b1;
            ctrl_o.reg_write = 1'b1;
         end
         rv_isa_pkg::OPC_LOAD: begin
            use_rs1          = 1'b1;
            ctrl_o.use_imm   = 1'b1;
            ctrl_o.reg_write = (funct3 == rv_isa_pkg::F3_WORD);
            ctrl_o.mem_read  = (funct3 == rv_isa_pkg::F3_WORD);
         end
         rv_isa_pkg::OPC_STORE: begin
            use_rs1          = 1'b1;
            use_rs2          = 1'b1;
            imm_o            = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            ctrl_o.use_imm   = 1'b1;
            ctrl_o.mem_write = (funct3 == rv_isa_pkg::F3_WORD);
         end
         rv_isa_pkg::OPC_BRANCH: begin
            use_rs1          = 1'b1;
            use_rs2          = 1'b1;
            imm_o            = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                                instr_i[30:25], instr_i[11:8], 1'b0};
            ctrl_o.is_branch = (funct3 == rv_isa_pkg::F3_BEQ) || (funct3 == rv_isa_pkg::F3_BNE);
            ctrl_o.branch_ne = (funct3 == rv_isa_pkg::F3_BNE);
         end
         rv_isa_pkg::OPC_JAL: begin
            imm_o            = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                                instr_i[20], instr_i[30:21], 1'b0};
            ctrl_o.reg_write = 1'b1;
            ctrl_o.is_jal    = 1'b1;
         end
         default: ctrl_o = '0;   // Unsupported, behaves as NOP
      endcase
   end

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
   input  logic                 clk,
   input  logic                 reset,
   input  rv_isa_pkg::reg_idx_t rs1_i,
   input  rv_isa_pkg::reg_idx_t rs2_i,
   input  rv_isa_pkg::reg_idx_t rd_i,
   input  logic                 we_i,
   input  rv_isa_pkg::word_t    wdata_i,
   output rv_isa_pkg::word_t    op1_o,
   output rv_isa_pkg::word_t    op2_o
);

   rv_isa_pkg::word_t regs [1:31];   // x0 has no storage

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we_i && rd_i != '0) begin
         regs[rd_i] <= wdata_i;
      end
   end

   // Write-through covers the WB to ID case
   assign op1_o = (rs1_i == '0) ? '0 : (we_i && rd_i == rs1_i) ? wdata_i : regs[rs1_i];
   assign op2_o = (rs2_i == '0) ? '0 : (we_i && rd_i == rs2_i) ? wdata_i : regs[rs2_i];

   a_x0_zero : assert property (
      @(posedge clk) disable iff (reset)
      (rs1_i == '0) |-> (op1_o == '0)
   ) else $error("reg_file: x0 read as %h", op1_o);

endmodule

`default_nettype wire

//--- src/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
   input  rv_pipe_pkg::id_ex_t  id_ex_i,
   input  rv_pipe_pkg::ex_mem_t ex_mem_i,
   input  rv_pipe_pkg::mem_wb_t mem_wb_i,
   output rv_pipe_pkg::ex_mem_t ex_mem_o,
   output logic                 redirect_o,
   output rv_isa_pkg::word_t    target_o
);

   logic              mem_fwd_ok;
   logic              wb_fwd_ok;
   rv_isa_pkg::word_t opa;
   rv_isa_pkg::word_t rs2_val;
   rv_isa_pkg::word_t opb;
   rv_isa_pkg::word_t alu_res;
   logic              equal;
   logic              taken;

   assign mem_fwd_ok = ex_mem_i.valid && ex_mem_i.ctrl.reg_write && (ex_mem_i.rd != '0);
   assign wb_fwd_ok  = mem_wb_i.valid && mem_wb_i.reg_write && (mem_wb_i.rd != '0);

   // Youngest producer first
   assign opa = (mem_fwd_ok && ex_mem_i.rd == id_ex_i.rs1) ? ex_mem_i.alu_result :
                (wb_fwd_ok && mem_wb_i.rd == id_ex_i.rs1)  ? mem_wb_i.result :
                id_ex_i.op1;
   assign rs2_val = (mem_fwd_ok && ex_mem_i.rd == id_ex_i.rs2) ? ex_mem_i.alu_result :
                    (wb_fwd_ok && mem_wb_i.rd == id_ex_i.rs2)  ? mem_wb_i.result :
                    id_ex_i.op2;
   assign opb = id_ex_i.ctrl.use_imm ? id_ex_i.imm : rs2_val;

   always_comb begin
      case (id_ex_i.ctrl.alu_op)
         rv_isa_pkg::ALU_ADD:    alu_res = opa + opb;
         rv_isa_pkg::ALU_SUB:    alu_res = opa - opb;
         rv_isa_pkg::ALU_AND:    alu_res = opa & opb;
         rv_isa_pkg::ALU_OR:     alu_res = opa | opb;
         rv_isa_pkg::ALU_XOR:    alu_res = opa ^ opb;
         rv_isa_pkg::ALU_SLT:    alu_res = {31'b0, $signed(opa) < $signed(opb)};
         rv_isa_pkg::ALU_PASS_B: alu_res = opb;
         default:                alu_res = opa + opb;
      endcase
   end

   // Branch compare uses the register operands, not the ALU
   assign equal = (opa == rs2_val);
   assign taken = id_ex_i.ctrl.is_branch && (id_ex_i.ctrl.branch_ne ? !equal : equal);

   assign redirect_o = id_ex_i.valid && (taken || id_ex_i.ctrl.is_jal);
   assign target_o   = id_ex_i.pc + id_ex_i.imm;

   always_comb begin
      ex_mem_o            = '0;
      ex_mem_o.valid      = id_ex_i.valid;
      ex_mem_o.pc         = id_ex_i.pc;
      ex_mem_o.rd         = id_ex_i.rd;
      ex_mem_o.alu_result = id_ex_i.ctrl.is_jal ? id_ex_i.pc + 32'd4 : alu_res;   // Link
      ex_mem_o.store_data = rs2_val;
      ex_mem_o.ctrl       = id_ex_i.ctrl;
   end

   always_comb begin
      a_no_ghost_redirect : assert final (id_ex_i.valid || !redirect_o)
         else $error("execute_unit: redirect from an empty EX slot");
   end

endmodule

`default_nettype wire

//--- src/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   fetch_req_i,
   input  rv_isa_pkg::word_t      fetch_addr_i,
   output logic                   fetch_gnt_o,
   output rv_isa_pkg::word_t      fetch_data_o,
   input  logic                   data_req_i,
   input  logic                   data_we_i,
   input  rv_isa_pkg::word_t      data_addr_i,
   input  rv_isa_pkg::word_t      data_wdata_i,
   output rv_isa_pkg::word_t      data_rdata_o,
   input  logic                   prog_we_i,
   input  rv_pipe_pkg::mem_addr_t prog_addr_i,
   input  rv_isa_pkg::word_t      prog_data_i
);

   rv_isa_pkg::word_t      mem [rv_pipe_pkg::MEM_WORDS];
   rv_pipe_pkg::mem_addr_t addr;
   rv_isa_pkg::word_t      rdata;

   // Fixed priority, data side always wins
   assign fetch_gnt_o = fetch_req_i && !data_req_i;

   // Single port, byte address to word index
   assign addr = data_req_i ? data_addr_i[rv_pipe_pkg::MEM_ADDR_W+1:2]
                            : fetch_addr_i[rv_pipe_pkg::MEM_ADDR_W+1:2];

   assign rdata        = mem[addr];
   assign fetch_data_o = rdata;
   assign data_rdata_o = rdata;

   always_ff @(posedge clk) begin
      if (reset) begin
         if (prog_we_i) begin
            mem[prog_addr_i] <= prog_data_i;   // Program load window
         end
      end else if (data_req_i && data_we_i) begin
         mem[addr] <= data_wdata_i;
      end
   end

   a_one_owner : assert property (
      @(posedge clk) disable iff (reset)
      data_req_i |-> !fetch_gnt_o
   ) else $error("mem_arbiter: fetch granted during a data access");

endmodule

`default_nettype wire

//--- src/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   prog_we_i,
   input  rv_pipe_pkg::mem_addr_t prog_addr_i,
   input  rv_isa_pkg::word_t      prog_data_i,
   output rv_pipe_pkg::retire_t   retire_o
);

   rv_pipe_pkg::if_id_t  if_id;
   rv_pipe_pkg::id_ex_t  id_ex;
   rv_pipe_pkg::id_ex_t  id_ex_d;
   rv_pipe_pkg::ex_mem_t ex_mem;
   rv_pipe_pkg::ex_mem_t ex_mem_d;
   rv_pipe_pkg::mem_wb_t mem_wb;
   rv_pipe_pkg::mem_wb_t mem_wb_d;

   rv_isa_pkg::word_t    pc;
   rv_isa_pkg::word_t    fetch_addr;
   rv_isa_pkg::word_t    fetch_data;
   rv_isa_pkg::word_t    target;
   rv_isa_pkg::word_t    data_rdata;
   rv_isa_pkg::word_t    dec_imm;
   rv_isa_pkg::word_t    rf_op1;
   rv_isa_pkg::word_t    rf_op2;
   rv_isa_pkg::reg_idx_t dec_rs1;
   rv_isa_pkg::reg_idx_t dec_rs2;
   rv_isa_pkg::reg_idx_t dec_rd;
   rv_pipe_pkg::ctrl_t   dec_ctrl;

   logic fetch_req;
   logic fetch_gnt;
   logic redirect;
   logic load_use;
   logic pc_hold;
   logic data_req;

   // Consumer in ID waits one cycle for a load in EX
   assign load_use = if_id.valid && id_ex.valid && id_ex.ctrl.mem_read && (id_ex.rd != '0) &&
                     (id_ex.rd == dec_rs1 || id_ex.rd == dec_rs2);
   assign pc_hold  = load_use || !fetch_gnt;
   assign data_req = ex_mem.valid && (ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write);

   fetch_unit u_fetch (
      .clk          (clk),
      .reset        (reset),
      .hold_i       (pc_hold),
      .redirect_i   (redirect),
      .target_i     (target),
      .fetch_req_o  (fetch_req),
      .fetch_addr_o (fetch_addr),
      .pc_o         (pc)
   );

   mem_arbiter u_mem (
      .clk          (clk),
      .reset        (reset),
      .fetch_req_i  (fetch_req),
      .fetch_addr_i (fetch_addr),
      .fetch_gnt_o  (fetch_gnt),
      .fetch_data_o (fetch_data),
      .data_req_i   (data_req),
      .data_we_i    (ex_mem.ctrl.mem_write),
      .data_addr_i  (ex_mem.alu_result),
      .data_wdata_i (ex_mem.store_data),
      .data_rdata_o (data_rdata),
      .prog_we_i    (prog_we_i),
      .prog_addr_i  (prog_addr_i),
      .prog_data_i  (prog_data_i)
   );

   decode_unit u_decode (
      .instr_i (if_id.instr),
      .rs1_o   (dec_rs1),
      .rs2_o   (dec_rs2),
      .rd_o    (dec_rd),
      .imm_o   (dec_imm),
      .ctrl_o  (dec_ctrl)
   );

   reg_file u_regs (
      .clk     (clk),
      .reset   (reset),
      .rs1_i   (dec_rs1),
      .rs2_i   (dec_rs2),
      .rd_i    (mem_wb.rd),
      .we_i    (mem_wb.valid && mem_wb.reg_write),
      .wdata_i (mem_wb.result),
      .op1_o   (rf_op1),
      .op2_o   (rf_op2)
   );

   execute_unit u_execute (
      .id_ex_i    (id_ex),
      .ex_mem_i   (ex_mem),
      .mem_wb_i   (mem_wb),
      .ex_mem_o   (ex_mem_d),
      .redirect_o (redirect),
      .target_o   (target)
   );

   assign id_ex_d  = '{valid: if_id.valid, pc: if_id.pc, rs1: dec_rs1, rs2: dec_rs2, rd: dec_rd,
                       op1: rf_op1, op2: rf_op2, imm: dec_imm, ctrl: dec_ctrl};
   assign mem_wb_d = '{valid: ex_mem.valid, pc: ex_mem.pc, rd: ex_mem.rd,
                       result: ex_mem.ctrl.mem_read ? data_rdata : ex_mem.alu_result,
                       reg_write: ex_mem.ctrl.reg_write};

   always_ff @(posedge clk) begin
      if (reset) begin
         if_id  <= rv_pipe_pkg::IF_BUBBLE;
         id_ex  <= '0;
         ex_mem <= '0;
         mem_wb <= '0;
      end else begin
         if (redirect || (!load_use && !fetch_gnt)) begin
            if_id <= rv_pipe_pkg::IF_BUBBLE;   // Flush or lost fetch
         end else if (!load_use) begin
            if_id <= '{valid: 1'b1, pc: pc, instr: fetch_data};
         end
         id_ex  <= (redirect || load_use) ? '0 : id_ex_d;
         ex_mem <= ex_mem_d;
         mem_wb <= mem_wb_d;
      end
   end

   assign retire_o = '{valid: mem_wb.valid, pc: mem_wb.pc, rd: mem_wb.rd, wdata: mem_wb.result,
                       we: mem_wb.reg_write && (mem_wb.rd != '0)};

   // No consumer reaches EX while its load is still in MEM
   a_no_load_forward : assert property (
      @(posedge clk) disable iff (reset)
      (ex_mem.valid && ex_mem.ctrl.mem_read && ex_mem.rd != '0 && id_ex.valid) |->
         (ex_mem.rd != id_ex.rs1 && ex_mem.rd != id_ex.rs2)
   ) else $error("rv_core_top: load result needed in EX before it was read");

endmodule

`default_nettype wire

//--- dv/core_model.svh
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

localparam int          PROG_LEN   = 160;   // Setup, random body, final loop
localparam int          DATA_WORDS = 8;
localparam logic [31:0] DATA_BASE  = 32'h0000_0400;
localparam logic [9:0]  DATA_WADDR = 10'(DATA_BASE >> 2);
localparam logic [31:0] LOOP_PC    = 32'(4 * (PROG_LEN - 1));
localparam logic [31:0] NOP        = 32'h0000_0013;

typedef struct packed {
   logic [31:0] pc;
   logic [4:0]  rd;
   logic [31:0] wdata;
   logic        we;
   logic        store;
   logic [31:0] st_addr;
   logic [31:0] st_data;
   logic [31:0] next_pc;
} expect_t;

logic [31:0] prog   [0:255];
logic [31:0] m_regs [0:31];
logic [31:0] m_dmem [0:DATA_WORDS-1];
logic [31:0] lfsr;

function automatic logic [31:0] data_fill(input logic [9:0] waddr);
   return 32'h3c6e_f372 ^ ({22'b0, waddr} * 32'h9e37_79b1);
endfunction

function automatic logic [31:0] take_bits(input int n);
   logic [31:0] v;
   v = '0;
   for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;   // Galois step
      v    = {v[30:0], lfsr[0]};
   end
   return v;
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
   return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
   return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// sel picks ADD, SUB, AND, OR, XOR, SLT, SUB, ADD
function automatic logic [31:0] alu_r(input logic [2:0] sel, input logic [4:0] rd,
                                      input logic [4:0] rs1, input logic [4:0] rs2);
   logic [2:0] f3;
   f3 = (sel == 3'd5) ? 3'b010 : (sel == 3'd2) ? 3'b111 : (sel == 3'd3) ? 3'b110 :
        (sel == 3'd4) ? 3'b100 : 3'b000;
   return {(sel == 3'd1 || sel == 3'd6) ? 7'b0100000 : 7'b0, rs2, rs1, f3, rd, 7'b0110011};
endfunction

task automatic gen_program();
   logic [4:0]  rd;
   logic [4:0]  rs1;
   logic [4:0]  rs2;
   logic [4:0]  prev_rd;
   logic [2:0]  kind;
   logic [12:0] offs;
   int          skip;
   prev_rd = 5'd1;
   prog[0] = enc_i(DATA_BASE[11:0], 5'd0, 3'b000, 5'd8, 7'b0010011);   // x8 holds data base
   for (int i = 1; i < PROG_LEN - 1; i++) begin
      kind = 3'(take_bits(3));
      rd   = 5'(take_bits(3));
      rs1  = (take_bits(1) != 0) ? prev_rd : 5'(take_bits(3));   // Back-to-back dependency
      rs2  = 5'(take_bits(3));
      skip = 1 + int'(take_bits(1));
      if (kind == 3'd7 && i + skip > PROG_LEN - 2) begin
         kind = 3'd3;   // Target would pass the final loop
      end
      offs = 13'(4 * (skip + 1));
      case (kind)
         3'd0, 3'd1, 3'd2: prog[i] = alu_r(3'(take_bits(3)), rd, rs1, rs2);
         3'd3: prog[i] = enc_i(12'(take_bits(12)), rs1, 3'b000, rd, 7'b0010011);
         3'd4: prog[i] = {20'(take_bits(20)), rd, 7'b0110111};
         3'd5: prog[i] = enc_i({7'b0, 3'(take_bits(3)), 2'b00}, 5'd8, 3'b010, rd, 7'b0000011);
         3'd6: prog[i] = enc_s({7'b0, 3'(take_bits(3)), 2'b00}, rs2, 5'd8);
         default: begin
            case (2'(take_bits(2)))
               2'd0:    prog[i] = enc_b(offs, rs2, rs1, 3'b000);
               2'd3:    prog[i] = enc_j({8'b0, offs}, rd);
               default: prog[i] = enc_b(offs, rs2, rs1, 3'b001);
            endcase
         end
      endcase
      prev_rd = rd;
   end
   prog[PROG_LEN - 1] = enc_j(21'd0, 5'd0);   // jal x0, 0
   prog[PROG_LEN]     = NOP;
   prog[PROG_LEN + 1] = NOP;
endtask

// ISA result of the instruction at pc, from the model state
function automatic expect_t predict(input logic [31:0] pc);
   expect_t     e;
   logic [31:0] ins;
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] imm_i;
   logic [31:0] ea;
   ins       = prog[pc[9:2]];
   a         = m_regs[ins[19:15]];
   b         = m_regs[ins[24:20]];
   imm_i     = {{20{ins[31]}}, ins[31:20]};
   ea        = a + imm_i;
   e         = '0;
   e.pc      = pc;
   e.rd      = ins[11:7];
   e.next_pc = pc + 32'd4;
   case (ins[6:0])
      7'b0110011: begin
         e.we = 1'b1;
         case (ins[14:12])
            3'b000:  e.wdata = ins[30] ? a - b : a + b;
            3'b010:  e.wdata = {31'b0, $signed(a) < $signed(b)};
            3'b100:  e.wdata = a ^ b;
            3'b110:  e.wdata = a | b;
            default: e.wdata = a & b;
         endcase
      end
      7'b0010011: begin
         e.we    = 1'b1;
         e.wdata = ea;
      end
      7'b0110111: begin
         e.we    = 1'b1;
         e.wdata = {ins[31:12], 12'b0};
      end
      7'b0000011: begin
         e.we    = 1'b1;
         e.wdata = m_dmem[ea[4:2]];
      end
      7'b0100011: begin
         e.store   = 1'b1;
         e.st_addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
         e.st_data = b;
      end
      7'b1100011: begin
         if ((a != b) == ins[12]) begin   // BEQ or BNE taken
            e.next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
         end
      end
      7'b1101111: begin
         e.we      = 1'b1;
         e.wdata   = pc + 32'd4;
         e.next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      default: e.we = 1'b0;
   endcase
   e.we = e.we && (e.rd != 5'd0);
   return e;
endfunction

`endif

//--- dv/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb;

   `include "core_model.svh"

   logic                   clk;
   logic                   reset;
   logic                   prog_we;
   rv_pipe_pkg::mem_addr_t prog_addr;
   logic [31:0]            prog_data;
   rv_pipe_pkg::retire_t   retire;

   expect_t exp_r;   // Next retire the model expects
   int      mismatches = 0;
   int      failures   = 0;
   int      retired;
   int      loop_hits;

   rv_core_top dut (
      .clk         (clk),
      .reset       (reset),
      .prog_we_i   (prog_we),
      .prog_addr_i (prog_addr),
      .prog_data_i (prog_data),
      .retire_o    (retire)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Model commits one instruction per retire strobe
   always @(posedge clk) begin
      if (reset) begin
         for (int r = 0; r < 32; r++) begin
            m_regs[r] = '0;
         end
         for (int k = 0; k < DATA_WORDS; k++) begin
            m_dmem[k] = data_fill(DATA_WADDR + 10'(k));
         end
         retired   = 0;
         loop_hits = 0;
         exp_r <= predict(32'd0);
      end else if (retire.valid) begin
         if (exp_r.we) begin
            m_regs[exp_r.rd] = exp_r.wdata;
         end
         if (exp_r.store) begin
            m_dmem[exp_r.st_addr[4:2]] = exp_r.st_data;
         end
         if (exp_r.pc == LOOP_PC) begin
            loop_hits++;
         end
         retired++;
         exp_r <= predict(exp_r.next_pc);
      end
   end

   a_quiet_in_reset : assert property (@(posedge clk) reset |=> !retire.valid)
      else begin
         mismatches++;
         $display("MISMATCH at %0t: retire strobe while in reset", $time);
      end

   a_retire_pc : assert property (@(posedge clk) disable iff (reset)
      retire.valid |-> retire.pc == exp_r.pc)
      else begin
         mismatches++;
         $display("MISMATCH at %0t: retired pc %h, expected %h", $time,
                  $sampled(retire.pc), $sampled(exp_r.pc));
      end

   a_retire_we : assert property (@(posedge clk) disable iff (reset)
      retire.valid |-> retire.we == exp_r.we)
      else begin
         mismatches++;
         $display("MISMATCH at %0t: pc %h we %b, expected %b", $time,
                  $sampled(retire.pc), $sampled(retire.we), $sampled(exp_r.we));
      end

   a_retire_data : assert property (@(posedge clk) disable iff (reset)
      (retire.valid && exp_r.we) |-> (retire.rd == exp_r.rd && retire.wdata == exp_r.wdata))
      else begin
         mismatches++;
         $display("MISMATCH at %0t: pc %h wrote x%0d=%h, expected x%0d=%h", $time,
                  $sampled(retire.pc), $sampled(retire.rd), $sampled(retire.wdata),
                  $sampled(exp_r.rd), $sampled(exp_r.wdata));
      end

   a_no_x0_write : assert property (@(posedge clk) disable iff (reset)
      retire.valid |-> !(retire.we && retire.rd == 5'd0))
      else begin
         mismatches++;
         $display("MISMATCH at %0t: write to x0 retired", $time);
      end

   task automatic write_word(input logic [9:0] addr, input logic [31:0] data);
      prog_we   = 1'b1;
      prog_addr = addr;
      prog_data = data;
      @(posedge clk);
      #1;
   endtask

   task automatic await_first_retire(output bit ok);
      int cycles;
      cycles = 0;
      while (!retire.valid && cycles < 20) begin
         @(negedge clk);
         cycles++;
      end
      ok = retire.valid;
      if (!ok) begin
         failures++;
         $display("core_tb: nothing retired within %0d cycles after reset", cycles);
      end
   endtask

   task automatic await_program_end(output bit ok);
      int cycles;
      cycles = 0;
      while (loop_hits < 3 && cycles < 4000) begin   // Final loop seen a few times
         @(negedge clk);
         cycles++;
      end
      ok = (loop_hits >= 3);
      if (!ok) begin
         failures++;
         $display("core_tb: program did not reach its final loop, %0d retired", retired);
      end
   endtask

   initial begin
      bit ok;
      reset     = 1'b1;
      prog_we   = 1'b0;
      prog_addr = '0;
      prog_data = '0;
      lfsr      = 32'h5a17372f;
      gen_program();
      @(posedge clk);
      #1;
      for (int i = 0; i < PROG_LEN + 2; i++) begin
         write_word(10'(i), prog[i]);
      end
      for (int k = 0; k < DATA_WORDS; k++) begin
         write_word(DATA_WADDR + 10'(k), data_fill(DATA_WADDR + 10'(k)));
      end
      prog_we = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
      await_first_retire(ok);
      if (ok) begin
         await_program_end(ok);
      end
      $display("core_tb: %0d mismatches, %0d other failures, %0d instructions retired",
               mismatches, failures, retired);
      if (mismatches == 0 && failures == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
+incdir+dv
src/rv_isa_pkg.sv
src/rv_pipe_pkg.sv
src/fetch_unit.sv
src/decode_unit.sv
src/reg_file.sv
src/execute_unit.sv
src/mem_arbiter.sv
src/rv_core_top.sv
dv/core_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run core_tb with Verilator, result decided from the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "run.sh: Verilator build failed"
   exit 1
fi

./obj_dir/Vcore_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "run.sh: simulation exited with status $status"
   exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
   exit 0
fi
exit 1
